// ==== rtl/soc_config.svh ====
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// Register port widths
`define SOC_DATA_W 16
`define SOC_ADDR_W 3

// SPI host
// Chip-select lines, at most one low at a time
`define SOC_SPI_NUM_CS 2

// System clock cycles per SPI clock half period
`define SOC_SPI_HALF_DIV 2

// UART
// Divider after reset, one bit lasts divider plus one cycles
`define SOC_UART_DIV_RST 7

`endif

// ==== rtl/soc_reg_pkg.sv ====
`default_nettype none
`include "soc_config.svh"

package soc_reg_pkg;

  // Register port vectors
  typedef logic [`SOC_ADDR_W-1:0] reg_addr_t;
  typedef logic [`SOC_DATA_W-1:0] reg_data_t;

  // Register map, unlisted addresses read as zero
  typedef enum reg_addr_t {
    REG_CTRL      = 0,
    REG_UART_DATA = 1,
    REG_SPI_DATA  = 2,
    REG_STATUS    = 3
  } reg_map_e;

  // Control register fields, divider sits in bits 7:0
  localparam int unsigned CTRL_DIV_MSB    = 7;
  localparam int unsigned CTRL_CS_IDX_BIT = 8;
  localparam int unsigned CTRL_CS_EN_BIT  = 9;

  // Status register fields
  localparam int unsigned STAT_UART_BUSY_BIT = 0;
  localparam int unsigned STAT_SPI_BUSY_BIT  = 1;

endpackage

`default_nettype wire

// ==== rtl/soc_io_pkg.sv ====
`default_nettype none
`include "soc_config.svh"

package soc_io_pkg;

  // One data unit on either serial line
  typedef logic [7:0] byte_t;

  // UART bit divider
  typedef logic [7:0] baud_div_t;

  // SPI chip selects, active low
  typedef logic [`SOC_SPI_NUM_CS-1:0] cs_vec_t;

  // 8N1 transmit frame
  typedef enum logic [1:0] {
    UART_IDLE,
    UART_START,
    UART_DATA,
    UART_STOP
  } uart_state_e;

  // Mode-0 transfer: lead half period, 8 clock pulses, trail half period
  typedef enum logic [1:0] {
    SPI_IDLE,
    SPI_LEAD,
    SPI_SHIFT,
    SPI_TRAIL
  } spi_state_e;

endpackage

`default_nettype wire

// ==== rtl/soc_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "soc_config.svh"

module soc_regfile
  import soc_reg_pkg::*;
  import soc_io_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  // Register port
  input  logic      reg_we_i,
  input  logic      reg_re_i,
  input  reg_addr_t reg_addr_i,
  input  reg_data_t reg_wdata_i,
  output reg_data_t reg_rdata_o,
  // UART
  output logic      uart_start_o,
  output byte_t     uart_byte_o,
  output baud_div_t uart_div_o,
  input  logic      uart_busy_i,
  // SPI host
  output logic      spi_start_o,
  output byte_t     spi_tx_byte_o,
  output logic      spi_cs_idx_o,
  output logic      spi_cs_en_o,
  input  logic      spi_busy_i,
  input  logic      spi_done_i,
  input  byte_t     spi_rx_byte_i
);

  reg_map_e  addr;
  logic      ctrl_wr;
  logic      uart_wr;
  logic      spi_wr;
  // Launch issued or transfer running
  logic      uart_pend;
  logic      spi_pend;

  baud_div_t div_q;
  logic      cs_idx_q;
  logic      cs_en_q;
  logic      uart_start_q;
  logic      spi_start_q;
  byte_t     uart_byte_q;
  byte_t     spi_tx_q;
  byte_t     spi_rx_q;
  reg_data_t rdata_d;
  reg_data_t rdata_q;

  ////////////////////////////////////////
  // Write decode
  ////////////////////////////////////////

  assign addr      = reg_map_e'(reg_addr_i);
  assign uart_pend = uart_busy_i | uart_start_q;
  assign spi_pend  = spi_busy_i | spi_start_q;

  // Data writes to a busy peripheral are dropped here
  assign ctrl_wr = reg_we_i && (addr == REG_CTRL);
  assign uart_wr = reg_we_i && (addr == REG_UART_DATA) && !uart_pend;
  assign spi_wr  = reg_we_i && (addr == REG_SPI_DATA) && !spi_pend;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      div_q        <= baud_div_t'(`SOC_UART_DIV_RST);
      cs_idx_q     <= 1'b0;
      cs_en_q      <= 1'b0;
      uart_start_q <= 1'b0;
      spi_start_q  <= 1'b0;
    end else begin
      if (ctrl_wr) begin
        div_q    <= reg_wdata_i[CTRL_DIV_MSB:0];
        cs_idx_q <= reg_wdata_i[CTRL_CS_IDX_BIT];
        cs_en_q  <= reg_wdata_i[CTRL_CS_EN_BIT];
      end
      // One-cycle launch pulses
      uart_start_q <= uart_wr;
      spi_start_q  <= spi_wr;
    end
  end

  always_ff @(posedge clk_i) begin
    if (uart_wr) begin
      uart_byte_q <= reg_wdata_i[7:0];
    end
    if (spi_wr) begin
      spi_tx_q <= reg_wdata_i[7:0];
    end
    // Receive byte is final at the end of the trail
    if (spi_done_i) begin
      spi_rx_q <= spi_rx_byte_i;
    end
  end

  ////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////

  always_comb begin
    rdata_d = '0;
    case (addr)
      REG_CTRL: begin
        rdata_d[CTRL_DIV_MSB:0]  = div_q;
        rdata_d[CTRL_CS_IDX_BIT] = cs_idx_q;
        rdata_d[CTRL_CS_EN_BIT]  = cs_en_q;
      end
      REG_SPI_DATA: rdata_d[7:0] = spi_rx_q;
      REG_STATUS: begin
        rdata_d[STAT_UART_BUSY_BIT] = uart_pend;
        rdata_d[STAT_SPI_BUSY_BIT]  = spi_pend;
      end
      default: rdata_d = '0;
    endcase
  end

  // Held until the next read strobe
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rdata_q <= '0;
    end else if (reg_re_i) begin
      rdata_q <= rdata_d;
    end
  end

  assign reg_rdata_o   = rdata_q;
  assign uart_start_o  = uart_start_q;
  assign uart_byte_o   = uart_byte_q;
  assign uart_div_o    = div_q;
  assign spi_start_o   = spi_start_q;
  assign spi_tx_byte_o = spi_tx_q;
  assign spi_cs_idx_o  = cs_idx_q;
  assign spi_cs_en_o   = cs_en_q;

  // Launch never reaches a UART still sending a frame
  a_uart_start_idle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(uart_start_o && uart_busy_i));

endmodule

`default_nettype wire

// ==== rtl/soc_uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_uart_tx
  import soc_io_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      start_i,
  input  byte_t     byte_i,
  input  baud_div_t div_i,
  output logic      busy_o,
  output logic      tx_o
);

  uart_state_e state_q;
  baud_div_t   div_q;
  baud_div_t   cnt_q;
  logic [2:0]  bit_q;
  byte_t       shift_q;
  logic        tx_q;
  logic        bit_end;

  // Counter runs down from the divider, so each bit is div plus one cycles
  assign bit_end = (cnt_q == '0);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= UART_IDLE;
      div_q   <= '0;
      cnt_q   <= '0;
      bit_q   <= '0;
      tx_q    <= 1'b1;
    end else begin
      if (state_q != UART_IDLE) begin
        cnt_q <= bit_end ? div_q : cnt_q - 1'b1;
      end
      case (state_q)
        UART_IDLE: begin
          // Divider latched here, control changes apply to the next frame
          if (start_i) begin
            state_q <= UART_START;
            div_q   <= div_i;
            cnt_q   <= div_i;
            tx_q    <= 1'b0;
          end
        end
        UART_START: begin
          if (bit_end) begin
            state_q <= UART_DATA;
            bit_q   <= '0;
            tx_q    <= shift_q[0];
          end
        end
        UART_DATA: begin
          if (bit_end) begin
            if (bit_q == 3'd7) begin
              state_q <= UART_STOP;
              tx_q    <= 1'b1;
            end else begin
              bit_q <= bit_q + 1'b1;
              tx_q  <= shift_q[1];
            end
          end
        end
        UART_STOP: begin
          if (bit_end) begin
            state_q <= UART_IDLE;
          end
        end
        default: state_q <= UART_IDLE;
      endcase
    end
  end

  // LSB first
  always_ff @(posedge clk_i) begin
    if (state_q == UART_IDLE && start_i) begin
      shift_q <= byte_i;
    end else if (state_q == UART_DATA && bit_end) begin
      shift_q <= shift_q >> 1;
    end
  end

  assign busy_o = (state_q != UART_IDLE);
  assign tx_o   = tx_q;

  a_tx_idle_high: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (state_q == UART_IDLE) |-> tx_o);

endmodule

`default_nettype wire

// ==== rtl/soc_spi_host.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "soc_config.svh"

module soc_spi_host
  import soc_io_pkg::*;
(
  input  logic    clk_i,
  input  logic    arst_n_i,
  input  logic    start_i,
  input  byte_t   tx_byte_i,
  input  logic    cs_idx_i,
  input  logic    cs_en_i,
  input  logic    sd_i,
  output logic    busy_o,
  output logic    done_o,
  output byte_t   rx_byte_o,
  output logic    sck_o,
  output cs_vec_t csb_o,
  output logic    sd_o,
  output logic    sd_en_o
);

  localparam int unsigned HALF_DIV = `SOC_SPI_HALF_DIV;
  localparam int unsigned CNT_W    = (HALF_DIV > 1) ? $clog2(HALF_DIV) : 1;

  spi_state_e       state_q;
  logic [CNT_W-1:0] cnt_q;
  logic [2:0]       bit_q;
  logic             sck_q;
  cs_vec_t          csb_q;
  byte_t            shift_q;
  logic             miso_q;
  logic             half_end;
  logic             sck_rise;
  logic             sck_fall;

  ////////////////////////////////////////
  // Clock generation
  ////////////////////////////////////////

  assign half_end = (cnt_q == CNT_W'(HALF_DIV - 1));

  // Half-period counter
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else if (state_q == SPI_IDLE || half_end) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // First rise ends the lead, the last low half leads into the trail
  assign sck_rise = half_end && !sck_q &&
                    (state_q == SPI_LEAD || (state_q == SPI_SHIFT && bit_q != 3'd7));
  assign sck_fall = half_end && sck_q && (state_q == SPI_SHIFT);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= SPI_IDLE;
      bit_q   <= '0;
      sck_q   <= 1'b0;
      csb_q   <= '1;
    end else begin
      case (state_q)
        SPI_IDLE: begin
          if (start_i) begin
            state_q <= SPI_LEAD;
            bit_q   <= '0;
            csb_q   <= cs_en_i ? ~(cs_vec_t'(1) << cs_idx_i) : '1;
          end
        end
        SPI_LEAD: begin
          if (sck_rise) begin
            state_q <= SPI_SHIFT;
            sck_q   <= 1'b1;
          end
        end
        SPI_SHIFT: begin
          if (sck_fall) begin
            sck_q <= 1'b0;
          end else if (sck_rise) begin
            sck_q <= 1'b1;
            bit_q <= bit_q + 1'b1;
          end else if (half_end) begin
            state_q <= SPI_TRAIL;
          end
        end
        SPI_TRAIL: begin
          if (half_end) begin
            state_q <= SPI_IDLE;
            csb_q   <= '1;
          end
        end
        default: state_q <= SPI_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////
  // Shift register
  ////////////////////////////////////////

  // MISO taken as SCK rises, shifted in while MOSI moves on the fall
  always_ff @(posedge clk_i) begin
    if (state_q == SPI_IDLE && start_i) begin
      shift_q <= tx_byte_i;
    end else if (sck_fall) begin
      shift_q <= {shift_q[6:0], miso_q};
    end
    if (sck_rise) begin
      miso_q <= sd_i;
    end
  end

  assign busy_o    = (state_q != SPI_IDLE);
  assign done_o    = (state_q == SPI_TRAIL) && half_end;
  assign rx_byte_o = shift_q;
  assign sck_o     = sck_q;
  assign csb_o     = csb_q;
  assign sd_o      = shift_q[7];
  assign sd_en_o   = (state_q != SPI_IDLE);

  a_one_cs_low: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $countones(~csb_o) <= 1);

  a_sck_idle_low: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (state_q != SPI_SHIFT) |-> !sck_o);

endmodule

`default_nettype wire

// ==== rtl/soc_periph_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_periph_top
  import soc_reg_pkg::*;
  import soc_io_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  // Register port
  input  logic      reg_we_i,
  input  logic      reg_re_i,
  input  reg_addr_t reg_addr_i,
  input  reg_data_t reg_wdata_i,
  output reg_data_t reg_rdata_o,
  // UART pin
  output logic      uart_tx_o,
  // SPI pins
  output logic      spi_sck_o,
  output cs_vec_t   spi_csb_o,
  output logic      spi_sd_o,
  output logic      spi_sd_en_o,
  input  logic      spi_sd_i
);

  logic      uart_start;
  byte_t     uart_byte;
  baud_div_t uart_div;
  logic      uart_busy;

  logic      spi_start;
  byte_t     spi_tx_byte;
  logic      spi_cs_idx;
  logic      spi_cs_en;
  logic      spi_busy;
  logic      spi_done;
  byte_t     spi_rx_byte;

  ////////////////////////////////////////
  // Register file
  ////////////////////////////////////////

  soc_regfile u_regfile (
    .clk_i         ( clk_i       ),
    .arst_n_i      ( arst_n_i    ),
    .reg_we_i      ( reg_we_i    ),
    .reg_re_i      ( reg_re_i    ),
    .reg_addr_i    ( reg_addr_i  ),
    .reg_wdata_i   ( reg_wdata_i ),
    .reg_rdata_o   ( reg_rdata_o ),
    .uart_start_o  ( uart_start  ),
    .uart_byte_o   ( uart_byte   ),
    .uart_div_o    ( uart_div    ),
    .uart_busy_i   ( uart_busy   ),
    .spi_start_o   ( spi_start   ),
    .spi_tx_byte_o ( spi_tx_byte ),
    .spi_cs_idx_o  ( spi_cs_idx  ),
    .spi_cs_en_o   ( spi_cs_en   ),
    .spi_busy_i    ( spi_busy    ),
    .spi_done_i    ( spi_done    ),
    .spi_rx_byte_i ( spi_rx_byte )
  );

  ////////////////////////////////////////
  // Peripherals
  ////////////////////////////////////////

  soc_uart_tx u_uart_tx (
    .clk_i    ( clk_i      ),
    .arst_n_i ( arst_n_i   ),
    .start_i  ( uart_start ),
    .byte_i   ( uart_byte  ),
    .div_i    ( uart_div   ),
    .busy_o   ( uart_busy  ),
    .tx_o     ( uart_tx_o  )
  );

  soc_spi_host u_spi_host (
    .clk_i     ( clk_i       ),
    .arst_n_i  ( arst_n_i    ),
    .start_i   ( spi_start   ),
    .tx_byte_i ( spi_tx_byte ),
    .cs_idx_i  ( spi_cs_idx  ),
    .cs_en_i   ( spi_cs_en   ),
    .sd_i      ( spi_sd_i    ),
    .busy_o    ( spi_busy    ),
    .done_o    ( spi_done    ),
    .rx_byte_o ( spi_rx_byte ),
    .sck_o     ( spi_sck_o   ),
    .csb_o     ( spi_csb_o   ),
    .sd_o      ( spi_sd_o    ),
    .sd_en_o   ( spi_sd_en_o )
  );

endmodule

`default_nettype wire

// ==== verif/fixture_soc.sv ====
`timescale 1ns/1ps
`default_nettype none

module fixture_soc
  import soc_reg_pkg::*;
  import soc_io_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  // Register port
  input  logic      reg_we_i,
  input  logic      reg_re_i,
  input  reg_addr_t reg_addr_i,
  input  reg_data_t reg_wdata_i,
  output reg_data_t reg_rdata_o,
  // Divider the sampler assumes for the next frame
  input  baud_div_t uart_div_i,
  output logic      uart_tx_o,
  output byte_t     uart_rx_byte_o,
  output logic      uart_rx_stop_o,
  output int        uart_rx_count_o,
  // SPI pins seen by the test
  output logic      spi_sck_o,
  output cs_vec_t   spi_csb_o,
  output logic      spi_sd_en_o
);

  localparam int CLK_NS = 8;

  logic       dut_sd;
  wire        spi_sd;
  wire        spi_miso;
  byte_t      mosi_shift;
  byte_t      reply;
  logic [2:0] bit_cnt;
  logic       reply_ready;
  logic       miso_bit;
  int         bit_ns;
  int         bit_idx;
  byte_t      rx_bits;

  soc_periph_top u_soc_periph_top (
    .clk_i       ( clk_i       ),
    .arst_n_i    ( arst_n_i    ),
    .reg_we_i    ( reg_we_i    ),
    .reg_re_i    ( reg_re_i    ),
    .reg_addr_i  ( reg_addr_i  ),
    .reg_wdata_i ( reg_wdata_i ),
    .reg_rdata_o ( reg_rdata_o ),
    .uart_tx_o   ( uart_tx_o   ),
    .spi_sck_o   ( spi_sck_o   ),
    .spi_csb_o   ( spi_csb_o   ),
    .spi_sd_o    ( dut_sd      ),
    .spi_sd_en_o ( spi_sd_en_o ),
    .spi_sd_i    ( spi_miso    )
  );

  ////////////////////////////////////////
  // SPI data pad and model device
  ////////////////////////////////////////

  // Host owns the pin while enabled, weak pull-up otherwise
  assign spi_sd = spi_sd_en_o ? dut_sd : 1'bz;
  pullup (spi_sd);

  // No reply before the first transfer, so the pull-up gives 8'hFF
  assign spi_miso = reply_ready ? miso_bit : 1'bz;
  pullup (spi_miso);

  always @(posedge spi_sck_o or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mosi_shift <= '0;
      bit_cnt    <= '0;
    end else begin
      mosi_shift <= {mosi_shift[6:0], spi_sd};
      bit_cnt    <= bit_cnt + 1'b1;
    end
  end

  // Next MISO bit on the falling clock, new reply after the eighth bit
  always @(negedge spi_sck_o or negedge arst_n_i) begin
    if (!arst_n_i) begin
      reply       <= 8'hFF;
      reply_ready <= 1'b0;
      miso_bit    <= 1'b1;
    end else if (bit_cnt == 3'd0) begin
      reply       <= ~mosi_shift;
      reply_ready <= 1'b1;
      miso_bit    <= ~mosi_shift[7];
    end else begin
      miso_bit <= reply[3'd7 - bit_cnt];
    end
  end

  ////////////////////////////////////////
  // UART line sampler
  ////////////////////////////////////////

  initial begin
    uart_rx_byte_o  = '0;
    uart_rx_stop_o  = 1'b0;
    uart_rx_count_o = 0;
  end

  // Mid-bit samples, start bit centre first
  always begin
    @(negedge uart_tx_o);
    bit_ns = (int'(uart_div_i) + 1) * CLK_NS;
    #(bit_ns / 2);
    for (bit_idx = 0; bit_idx < 8; bit_idx++) begin
      #(bit_ns);
      rx_bits[bit_idx] = uart_tx_o;
    end
    #(bit_ns);
    uart_rx_stop_o  = uart_tx_o;
    uart_rx_byte_o  = rx_bits;
    uart_rx_count_o = uart_rx_count_o + 1;
  end

endmodule

`default_nettype wire

// ==== verif/tb_soc.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "soc_config.svh"

module tb_soc
  import soc_reg_pkg::*;
  import soc_io_pkg::*;
();

  logic        clk;
  logic        arst_n;
  logic        reg_we;
  logic        reg_re;
  reg_addr_t   reg_addr;
  reg_data_t   reg_wdata;
  reg_data_t   reg_rdata;
  baud_div_t   uart_div;
  logic        uart_tx;
  byte_t       uart_rx_byte;
  logic        uart_rx_stop;
  int          uart_rx_count;
  logic        spi_sck;
  cs_vec_t     spi_csb;
  logic        spi_sd_en;

  logic [31:0] lfsr;
  int          checks;
  int          errors;
  cs_vec_t     exp_csb;
  cs_vec_t     csb_low_seen;
  int          sck_rises;
  byte_t       spi_expect;

  always #4 clk = ~clk;

  fixture_soc u_fixture (
    .clk_i           ( clk           ),
    .arst_n_i        ( arst_n        ),
    .reg_we_i        ( reg_we        ),
    .reg_re_i        ( reg_re        ),
    .reg_addr_i      ( reg_addr      ),
    .reg_wdata_i     ( reg_wdata     ),
    .reg_rdata_o     ( reg_rdata     ),
    .uart_div_i      ( uart_div      ),
    .uart_tx_o       ( uart_tx       ),
    .uart_rx_byte_o  ( uart_rx_byte  ),
    .uart_rx_stop_o  ( uart_rx_stop  ),
    .uart_rx_count_o ( uart_rx_count ),
    .spi_sck_o       ( spi_sck       ),
    .spi_csb_o       ( spi_csb       ),
    .spi_sd_en_o     ( spi_sd_en     )
  );

  ////////////////////////////////////////
  // Checks and helpers
  ////////////////////////////////////////

  task automatic check_value(input string name, input logic [15:0] exp,
                             input logic [15:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("Mismatch at %0d ns: %s expected %0h, got %0h", $time, name, exp, act);
    end
  endtask

  // Chip selects sampled mid-cycle while a transfer runs
  always @(negedge clk) begin
    if (arst_n && spi_sd_en) begin
      csb_low_seen = csb_low_seen | ~spi_csb;
      check_value("spi_csb_o", 16'(exp_csb), 16'(spi_csb));
    end
  end

  always @(posedge spi_sck) begin
    sck_rises = sck_rises + 1;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] next;
    next = state >> 1;
    if (state[0]) begin
      next = next ^ 32'hA3000000;
    end
    return next;
  endfunction

  task automatic random_byte(output byte_t value);
    value = '0;
    for (int i = 0; i < 8; i++) begin
      lfsr  = lfsr_next(lfsr);
      value = {value[6:0], lfsr[0]};
    end
  endtask

  task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
    @(negedge clk);
    reg_we    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge clk);
    reg_we = 1'b0;
  endtask

  // Read data is registered, so it is stable one cycle later
  task automatic read_reg(input reg_addr_t addr, output reg_data_t data);
    @(negedge clk);
    reg_re   = 1'b1;
    reg_addr = addr;
    @(negedge clk);
    reg_re = 1'b0;
    data   = reg_rdata;
  endtask

  task automatic set_ctrl(input baud_div_t div, input logic cs_idx, input logic cs_en);
    uart_div = div;
    write_reg(REG_CTRL, {6'd0, cs_en, cs_idx, div});
  endtask

  task automatic poll_idle(input int bit_idx, input string what);
    reg_data_t status;
    int        polls;
    polls = 0;
    read_reg(REG_STATUS, status);
    while (status[bit_idx] && polls < 200) begin
      read_reg(REG_STATUS, status);
      polls++;
    end
    checks++;
    assert (!status[bit_idx]) else begin
      errors++;
      $display("Timeout at %0d ns: %s stayed busy through %0d status reads",
               $time, what, polls);
    end
  endtask

  task automatic wait_uart_count(input int count, input int max_cycles);
    int cycles;
    cycles = 0;
    while (uart_rx_count < count && cycles < max_cycles) begin
      @(negedge clk);
      cycles++;
    end
  endtask

  ////////////////////////////////////////
  // Scenarios
  ////////////////////////////////////////

  task automatic uart_frame();
    byte_t     data;
    reg_data_t status;
    int        count;
    random_byte(data);
    count = uart_rx_count;
    write_reg(REG_UART_DATA, 16'(data));
    read_reg(REG_STATUS, status);
    check_value("REG_STATUS uart busy", 16'd1, 16'(status[0]));
    poll_idle(0, "UART");
    wait_uart_count(count + 1, 20);
    check_value("uart_rx_count", 16'(count + 1), 16'(uart_rx_count));
    check_value("uart_rx_byte", 16'(data), 16'(uart_rx_byte));
    check_value("uart stop bit", 16'd1, 16'(uart_rx_stop));
  endtask

  task automatic spi_transfer(input cs_vec_t csb_expect);
    byte_t     data;
    reg_data_t rd;
    int        rises;
    random_byte(data);
    exp_csb      = csb_expect;
    csb_low_seen = '0;
    rises        = sck_rises;
    write_reg(REG_SPI_DATA, 16'(data));
    poll_idle(1, "SPI host");
    check_value("spi_sck_o rises", 16'd8, 16'(sck_rises - rises));
    check_value("spi_csb_o low bits", 16'(cs_vec_t'(~csb_expect)), 16'(csb_low_seen));
    read_reg(REG_SPI_DATA, rd);
    check_value("REG_SPI_DATA", 16'(spi_expect), rd);
    // Model device answers with the inverse of this byte next time
    spi_expect = ~data;
  endtask

  task automatic busy_drop();
    byte_t     first_byte;
    byte_t     second_byte;
    reg_data_t rd;
    int        count;
    random_byte(first_byte);
    random_byte(second_byte);
    count = uart_rx_count;
    write_reg(REG_UART_DATA, 16'(first_byte));
    write_reg(REG_UART_DATA, 16'(second_byte));
    poll_idle(0, "UART");
    // Long enough for a second frame to show up
    wait_uart_count(count + 2, 12 * (int'(uart_div) + 1));
    check_value("uart_rx_count", 16'(count + 1), 16'(uart_rx_count));
    check_value("uart_rx_byte", 16'(first_byte), 16'(uart_rx_byte));
    write_reg(3'd5, {second_byte, first_byte});
    read_reg(3'd5, rd);
    check_value("unused register", 16'd0, rd);
  endtask

  initial begin
    reg_data_t rd;
    clk          = 1'b0;
    arst_n       = 1'b0;
    reg_we       = 1'b0;
    reg_re       = 1'b0;
    reg_addr     = '0;
    reg_wdata    = '0;
    uart_div     = baud_div_t'(`SOC_UART_DIV_RST);
    lfsr         = 32'd98953;
    checks       = 0;
    errors       = 0;
    exp_csb      = '1;
    csb_low_seen = '0;
    sck_rises    = 0;
    spi_expect   = 8'hFF;
    repeat (3) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    // Reset state
    check_value("uart_tx_o", 16'd1, 16'(uart_tx));
    check_value("spi_csb_o", 16'(cs_vec_t'('1)), 16'(spi_csb));
    check_value("spi_sck_o", 16'd0, 16'(spi_sck));
    check_value("spi_sd_en_o", 16'd0, 16'(spi_sd_en));
    read_reg(REG_STATUS, rd);
    check_value("REG_STATUS", 16'd0, rd);
    read_reg(REG_CTRL, rd);
    check_value("REG_CTRL", 16'(`SOC_UART_DIV_RST), rd);

    set_ctrl(8'd3, 1'b0, 1'b0);
    repeat (3) uart_frame();
    set_ctrl(8'd7, 1'b0, 1'b0);
    repeat (3) uart_frame();

    // Loopback on chip select 0
    set_ctrl(8'd7, 1'b0, 1'b1);
    repeat (6) spi_transfer(2'b10);

    set_ctrl(8'd7, 1'b0, 1'b0);
    spi_transfer(2'b11);
    set_ctrl(8'd7, 1'b1, 1'b1);
    spi_transfer(2'b01);

    busy_drop();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+rtl
rtl/soc_reg_pkg.sv
rtl/soc_io_pkg.sv
rtl/soc_regfile.sv
rtl/soc_uart_tx.sv
rtl/soc_spi_host.sv
rtl/soc_periph_top.sv
verif/fixture_soc.sv
verif/tb_soc.sv
